/* compile.f */
source/video_dma_pkg.sv
source/dma_control_regs.sv
source/frame_address_gen.sv
source/stream_to_memory.sv
source/video_in_dma.sv
test/tb_clock_gen.sv
test/video_in_dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= video_in_dma_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -Wno-fatal
PASS_TEXT ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* test/video_in_dma_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module video_in_dma_tb;

	localparam int PIXELS = video_dma_pkg::FRAME_WIDTH * video_dma_pkg::FRAME_HEIGHT;
	localparam int MAX_ACK_DELAY = 3;
	// Frames over all tests including discarded ones
	localparam int FRAME_COUNT = 6;
	// Handshake gap and a full write per pixel plus margin for register accesses
	localparam int CYCLE_LIMIT = FRAME_COUNT * PIXELS * (MAX_ACK_DELAY + 6) + 1000;
	// Height in the upper half word and width in the lower
	localparam video_dma_pkg::wb_data_t RESOLUTION_WORD =
		(video_dma_pkg::FRAME_HEIGHT << 16) | video_dma_pkg::FRAME_WIDTH;

	logic clk;
	logic reset;
	video_dma_pkg::pixel_t stream_data;
	logic stream_sop;
	logic stream_eop;
	logic stream_valid;
	logic stream_ready;
	logic slave_cyc;
	logic slave_stb;
	logic slave_we;
	video_dma_pkg::reg_index_t slave_adr;
	video_dma_pkg::wb_sel_t slave_sel;
	video_dma_pkg::wb_data_t slave_dat_w;
	video_dma_pkg::wb_data_t slave_dat_r;
	logic slave_ack;
	logic master_cyc;
	logic master_stb;
	logic master_we;
	video_dma_pkg::wb_addr_t master_adr;
	video_dma_pkg::wb_sel_t master_sel;
	video_dma_pkg::wb_data_t master_dat_w;
	logic master_ack = 1'b0;

	int seed = 13717;
	int error_count = 0;
	int protocol_count = 0;
	int cycle_count = 0;
	// Memory model state
	logic random_delay = 1'b0;
	logic pending = 1'b0;
	int delay_left;
	video_dma_pkg::wb_addr_t held_adr;
	video_dma_pkg::wb_sel_t held_sel;
	video_dma_pkg::wb_data_t held_dat;
	video_dma_pkg::pixel_t mem [video_dma_pkg::wb_addr_t];
	// Writes seen by memory and writes the tests expect
	video_dma_pkg::wb_addr_t got_addr_q[$];
	video_dma_pkg::pixel_t got_pix_q[$];
	video_dma_pkg::wb_addr_t exp_addr_q[$];
	video_dma_pkg::pixel_t exp_pix_q[$];
	// Expected register contents
	video_dma_pkg::wb_addr_t exp_front;
	video_dma_pkg::wb_addr_t exp_back;
	video_dma_pkg::wb_data_t enable_word;
	video_dma_pkg::wb_data_t swap_word;

	tb_clock_gen u_clock (
		.clk(clk)
	);

	video_in_dma dut (
		.clk(clk),
		.reset(reset),
		.stream_data(stream_data),
		.stream_sop(stream_sop),
		.stream_eop(stream_eop),
		.stream_valid(stream_valid),
		.stream_ready(stream_ready),
		.slave_cyc(slave_cyc),
		.slave_stb(slave_stb),
		.slave_we(slave_we),
		.slave_adr(slave_adr),
		.slave_sel(slave_sel),
		.slave_dat_w(slave_dat_w),
		.slave_dat_r(slave_dat_r),
		.slave_ack(slave_ack),
		.master_cyc(master_cyc),
		.master_stb(master_stb),
		.master_we(master_we),
		.master_adr(master_adr),
		.master_sel(master_sel),
		.master_dat_w(master_dat_w),
		.master_ack(master_ack)
	);

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		protocol_count++;
	endtask

	task automatic check_addr(input string name, input video_dma_pkg::wb_addr_t exp,
		input video_dma_pkg::wb_addr_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_pixel(input string name, input video_dma_pkg::pixel_t exp,
		input video_dma_pkg::pixel_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_word(input string name, input video_dma_pkg::wb_data_t exp,
		input video_dma_pkg::wb_data_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	// Memory model acks after 0 to 3 wait cycles and stores the selected byte
	always @(posedge clk)
	begin
		if (reset)
		begin
			master_ack <= 1'b0;
			pending = 1'b0;
		end
		else if (master_ack)
			master_ack <= 1'b0;
		else if (master_cyc)
		begin
			if (!master_stb || !master_we)
				report_error("stb or we low during a master cycle");
			if (!pending)
			begin
				pending = 1'b1;
				held_adr = master_adr;
				held_sel = master_sel;
				held_dat = master_dat_w;
				delay_left = random_delay ? {$random(seed)} % (MAX_ACK_DELAY + 1) : 0;
				// Exactly one lane set and it is the one the low address bits name
				if (!$onehot(master_sel) || !master_sel[master_adr[1:0]])
					report_error("sel does not match the byte address");
				if (master_dat_w !== {4{master_dat_w[7:0]}})
					report_error("pixel not copied to all four byte lanes");
			end
			else if (master_adr !== held_adr || master_sel !== held_sel
				|| master_dat_w !== held_dat)
				report_error("address, sel or data changed before ack");
			if (delay_left == 0)
			begin
				master_ack <= 1'b1;
				mem[held_adr] = held_dat[8*held_adr[1:0] +: 8];
				got_addr_q.push_back(held_adr);
				got_pix_q.push_back(held_dat[8*held_adr[1:0] +: 8]);
				pending = 1'b0;
			end
			else
				delay_left--;
		end
		else if (pending)
			report_error("master cycle dropped before ack");
	end

	// No new pixel while a write is outstanding
	always @(negedge clk)
	begin
		if (!reset && master_cyc && stream_ready)
			report_error("stream_ready high while a write is pending");
	end

	// Cycle count for the watchdog
	always @(posedge clk)
		cycle_count++;

	// Watchdog ends a run that hangs
	initial
	begin
		while (cycle_count <= CYCLE_LIMIT)
			@(posedge clk);
		$display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

	// One slave access with ack exactly one cycle after the request
	task automatic access_register(input logic we, input video_dma_pkg::reg_index_t adr,
		input video_dma_pkg::wb_data_t data, input video_dma_pkg::wb_sel_t sel,
		output video_dma_pkg::wb_data_t rdata);
		@(posedge clk);
		slave_cyc <= 1'b1;
		slave_stb <= 1'b1;
		slave_we <= we;
		slave_adr <= adr;
		slave_sel <= sel;
		slave_dat_w <= data;
		@(negedge clk);
		if (slave_ack)
			report_error("slave ack before the request was seen");
		@(negedge clk);
		if (!slave_ack)
			report_error("slave ack missing one cycle after the request");
		while (!slave_ack)
			@(negedge clk);
		rdata = slave_dat_r;
		@(posedge clk);
		slave_cyc <= 1'b0;
		slave_stb <= 1'b0;
		slave_we <= 1'b0;
		@(negedge clk);
		if (slave_ack)
			report_error("slave ack longer than one cycle");
	endtask

	task automatic write_register(input video_dma_pkg::reg_index_t adr,
		input video_dma_pkg::wb_data_t data, input video_dma_pkg::wb_sel_t sel);
		video_dma_pkg::wb_data_t unused;
		access_register(1'b1, adr, data, sel, unused);
	endtask

	task automatic read_register(input video_dma_pkg::reg_index_t adr,
		output video_dma_pkg::wb_data_t data);
		access_register(1'b0, adr, '0, 4'hf, data);
	endtask

	task automatic expect_register(input string name, input video_dma_pkg::reg_index_t adr,
		input video_dma_pkg::wb_data_t exp);
		video_dma_pkg::wb_data_t data;
		read_register(adr, data);
		check_word(name, exp, data);
	endtask

	// Hold valid until ready and finish the handshake on the next edge
	task automatic send_pixel(input video_dma_pkg::pixel_t pix, input logic sop,
		input logic eop, input logic expect_ready);
		@(posedge clk);
		stream_data <= pix;
		stream_sop <= sop;
		stream_eop <= eop;
		stream_valid <= 1'b1;
		@(negedge clk);
		if (expect_ready && !stream_ready)
			report_error("stream_ready low while pixels are discarded");
		while (!stream_ready)
			@(negedge clk);
		@(posedge clk);
		stream_valid <= 1'b0;
		stream_sop <= 1'b0;
		stream_eop <= 1'b0;
	endtask

	// Pixels first to last of a frame with sop at 0 and eop at the end
	task automatic stream_frame_span(input video_dma_pkg::wb_addr_t base, input int first,
		input int last, input logic expect_write);
		int idx;
		video_dma_pkg::pixel_t pix;
		for (idx = first; idx <= last; idx++)
		begin
			pix = video_dma_pkg::pixel_t'($random(seed));
			send_pixel(pix, idx == 0, idx == PIXELS - 1, !expect_write);
			if (expect_write)
			begin
				// Byte offset row * width + column
				exp_addr_q.push_back(base + video_dma_pkg::wb_addr_t'(
					(idx / video_dma_pkg::FRAME_WIDTH) * video_dma_pkg::FRAME_WIDTH
					+ idx % video_dma_pkg::FRAME_WIDTH));
				exp_pix_q.push_back(pix);
			end
		end
	endtask

	// Wait for the expected writes, then compare order, address and memory
	task automatic drain_and_compare(input string name);
		video_dma_pkg::wb_addr_t addr;
		video_dma_pkg::pixel_t pix;
		// Latest byte expected at each address
		video_dma_pkg::pixel_t final_pix [video_dma_pkg::wb_addr_t];
		int i;
		while (got_addr_q.size() < exp_addr_q.size())
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (got_addr_q.size() != exp_addr_q.size())
		begin
			$display("ERROR: %s saw %0d memory writes, %0d expected", name,
				got_addr_q.size(), exp_addr_q.size());
			protocol_count++;
		end
		// A later frame overwrites an earlier one at the same address
		for (i = 0; i < exp_addr_q.size(); i++)
			final_pix[exp_addr_q[i]] = exp_pix_q[i];
		while (exp_addr_q.size() > 0 && got_addr_q.size() > 0)
		begin
			addr = exp_addr_q.pop_front();
			pix = exp_pix_q.pop_front();
			check_addr(name, addr, got_addr_q.pop_front());
			check_pixel(name, pix, got_pix_q.pop_front());
		end
		if (final_pix.first(addr))
		begin
			do
			begin
				if (mem.exists(addr))
					check_pixel(name, final_pix[addr], mem[addr]);
				else
					report_error("expected address never written in memory");
			end
			while (final_pix.next(addr));
		end
		exp_addr_q.delete();
		exp_pix_q.delete();
		got_addr_q.delete();
		got_pix_q.delete();
	endtask

	task automatic register_access_test();
		if (master_cyc || slave_ack || !stream_ready)
			report_error("outputs not at their reset values");
		expect_register("reset front", video_dma_pkg::REG_FRONT, exp_front);
		expect_register("reset back", video_dma_pkg::REG_BACK, exp_back);
		expect_register("reset status", video_dma_pkg::REG_STATUS, '0);
		expect_register("resolution", video_dma_pkg::REG_RESOLUTION, RESOLUTION_WORD);
		write_register(video_dma_pkg::REG_BACK, 32'h1234_5678, 4'hf);
		expect_register("back write", video_dma_pkg::REG_BACK, 32'h1234_5678);
		// Low two bytes only
		write_register(video_dma_pkg::REG_BACK, 32'hffff_3000, 4'b0011);
		exp_back = 32'h1234_3000;
		expect_register("back partial write", video_dma_pkg::REG_BACK, exp_back);
		write_register(video_dma_pkg::REG_RESOLUTION, 32'hffff_ffff, 4'hf);
		expect_register("resolution read-only", video_dma_pkg::REG_RESOLUTION,
			RESOLUTION_WORD);
		write_register(video_dma_pkg::REG_STATUS, enable_word, 4'hf);
		expect_register("enable set", video_dma_pkg::REG_STATUS, enable_word);
	endtask

	task automatic frame_capture_test();
		random_delay = 1'b0;
		stream_frame_span(exp_front, 0, PIXELS - 1, 1'b1);
		drain_and_compare("frame capture");
	endtask

	task automatic back_pressure_test();
		random_delay = 1'b1;
		stream_frame_span(exp_front, 0, PIXELS - 1, 1'b1);
		stream_frame_span(exp_front, 0, PIXELS - 1, 1'b1);
		drain_and_compare("back-pressure");
	endtask

	task automatic buffer_swap_test();
		video_dma_pkg::wb_addr_t old_front;
		old_front = exp_front;
		stream_frame_span(old_front, 0, PIXELS / 2 - 1, 1'b1);
		// Swap request in mid frame with its data ignored
		write_register(video_dma_pkg::REG_FRONT, 32'h0, 4'hf);
		expect_register("swap pending", video_dma_pkg::REG_STATUS, enable_word | swap_word);
		expect_register("front held", video_dma_pkg::REG_FRONT, old_front);
		stream_frame_span(old_front, PIXELS / 2, PIXELS - 2, 1'b1);
		drain_and_compare("swap old buffer");
		expect_register("swap before eop", video_dma_pkg::REG_STATUS, enable_word | swap_word);
		stream_frame_span(old_front, PIXELS - 1, PIXELS - 1, 1'b1);
		drain_and_compare("swap eop pixel");
		exp_front = exp_back;
		exp_back = old_front;
		expect_register("swap cleared", video_dma_pkg::REG_STATUS, enable_word);
		expect_register("front swapped", video_dma_pkg::REG_FRONT, exp_front);
		expect_register("back swapped", video_dma_pkg::REG_BACK, exp_back);
		stream_frame_span(exp_front, 0, PIXELS - 1, 1'b1);
		drain_and_compare("swap new buffer");
	endtask

	task automatic discard_test();
		int i;
		// Outside a frame with no sop yet
		for (i = 0; i < 4; i++)
			send_pixel(video_dma_pkg::pixel_t'($random(seed)), 1'b0, i == 3, 1'b1);
		drain_and_compare("discard outside frame");
		write_register(video_dma_pkg::REG_STATUS, '0, 4'hf);
		stream_frame_span(exp_front, 0, PIXELS - 1, 1'b0);
		drain_and_compare("discard while disabled");
	endtask

	initial
	begin
		reset = 1'b1;
		stream_data = '0;
		stream_sop = 1'b0;
		stream_eop = 1'b0;
		stream_valid = 1'b0;
		slave_cyc = 1'b0;
		slave_stb = 1'b0;
		slave_we = 1'b0;
		slave_adr = '0;
		slave_sel = '0;
		slave_dat_w = '0;
		exp_front = video_dma_pkg::DEFAULT_FRONT_ADDR;
		exp_back = video_dma_pkg::DEFAULT_BACK_ADDR;
		enable_word = video_dma_pkg::wb_data_t'(1) << video_dma_pkg::STATUS_ENABLE_BIT;
		swap_word = video_dma_pkg::wb_data_t'(1) << video_dma_pkg::STATUS_SWAP_BIT;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		register_access_test();
		frame_capture_test();
		back_pressure_test();
		buffer_swap_test();
		discard_test();
		$display("Value errors: %0d, protocol errors: %0d", error_count, protocol_count);
		if (error_count == 0 && protocol_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	// 8 ns period, starts low
	initial clk = 1'b0;
	always #4 clk = ~clk;

endmodule

`default_nettype wire

/* source/video_in_dma.sv */
`timescale 1ns/1ns
`default_nettype none

module video_in_dma (
	input logic clk,
	input logic reset,
	// Pixel stream in
	input video_dma_pkg::pixel_t stream_data,
	input logic stream_sop,
	input logic stream_eop,
	input logic stream_valid,
	output logic stream_ready,
	// Register slave
	input logic slave_cyc,
	input logic slave_stb,
	input logic slave_we,
	input video_dma_pkg::reg_index_t slave_adr,
	input video_dma_pkg::wb_sel_t slave_sel,
	input video_dma_pkg::wb_data_t slave_dat_w,
	output video_dma_pkg::wb_data_t slave_dat_r,
	output logic slave_ack,
	// Memory write master
	output logic master_cyc,
	output logic master_stb,
	output logic master_we,
	output video_dma_pkg::wb_addr_t master_adr,
	output video_dma_pkg::wb_sel_t master_sel,
	output video_dma_pkg::wb_data_t master_dat_w,
	input logic master_ack
);

	// Between registers and datapath
	video_dma_pkg::wb_addr_t front_addr;
	logic dma_enable;
	logic frame_done;
	// Address counter control
	logic addr_clear;
	logic addr_step;
	video_dma_pkg::wb_addr_t pixel_addr;

	dma_control_regs u_regs (
		.clk(clk),
		.reset(reset),
		.slave_cyc(slave_cyc),
		.slave_stb(slave_stb),
		.slave_we(slave_we),
		.slave_adr(slave_adr),
		.slave_sel(slave_sel),
		.slave_dat_w(slave_dat_w),
		.frame_done(frame_done),
		.slave_dat_r(slave_dat_r),
		.slave_ack(slave_ack),
		.front_addr(front_addr),
		.dma_enable(dma_enable)
	);

	frame_address_gen u_addr (
		.clk(clk),
		.reset(reset),
		.addr_clear(addr_clear),
		.addr_step(addr_step),
		.front_addr(front_addr),
		.pixel_addr(pixel_addr)
	);

	stream_to_memory u_writer (
		.clk(clk),
		.reset(reset),
		.stream_data(stream_data),
		.stream_sop(stream_sop),
		.stream_eop(stream_eop),
		.stream_valid(stream_valid),
		.master_ack(master_ack),
		.pixel_addr(pixel_addr),
		.dma_enable(dma_enable),
		.stream_ready(stream_ready),
		.master_cyc(master_cyc),
		.master_stb(master_stb),
		.master_we(master_we),
		.master_adr(master_adr),
		.master_sel(master_sel),
		.master_dat_w(master_dat_w),
		.frame_done(frame_done),
		.addr_clear(addr_clear),
		.addr_step(addr_step)
	);

endmodule

`default_nettype wire

/* source/stream_to_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module stream_to_memory (
	input logic clk,
	input logic reset,
	input video_dma_pkg::pixel_t stream_data,
	input logic stream_sop,
	input logic stream_eop,
	input logic stream_valid,
	input logic master_ack,
	input video_dma_pkg::wb_addr_t pixel_addr,
	input logic dma_enable,
	output logic stream_ready,
	output logic master_cyc,
	output logic master_stb,
	output logic master_we,
	output video_dma_pkg::wb_addr_t master_adr,
	output video_dma_pkg::wb_sel_t master_sel,
	output video_dma_pkg::wb_data_t master_dat_w,
	output logic frame_done,
	output logic addr_clear,
	output logic addr_step
);

	video_dma_pkg::dma_state_t state;
	// Pixel held for the bus write
	video_dma_pkg::pixel_t pixel_reg;
	video_dma_pkg::wb_addr_t addr_reg;
	logic eop_reg;
	// Between sop and eop
	logic in_frame;
	// Stream handshake
	logic accept;
	// Handshake that leads to a memory write
	logic capture;
	// Write acknowledged by memory
	logic write_done;

	// Ready only while no write is outstanding
	assign stream_ready = (state == video_dma_pkg::ST_IDLE);
	assign accept = stream_valid & stream_ready;

	// Outside a frame or disabled, the pixel is dropped
	assign capture = accept & dma_enable & (in_frame | stream_sop);
	assign addr_clear = accept & dma_enable & stream_sop;

	assign write_done = (state == video_dma_pkg::ST_WRITE) & master_ack;
	assign addr_step = write_done;
	// Pulse on the ack of the last pixel
	assign frame_done = write_done & eop_reg;

	// Write FSM
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= video_dma_pkg::ST_IDLE;
		else
		begin
			case (state)
				video_dma_pkg::ST_IDLE:
					if (capture)
						state <= video_dma_pkg::ST_WRITE;
				// Stay here as long as memory stalls
				video_dma_pkg::ST_WRITE:
					if (master_ack)
						state <= video_dma_pkg::ST_IDLE;
				default: state <= video_dma_pkg::ST_IDLE;
			endcase
		end
	end

	// Frame tracking, disable drops the current frame
	always_ff @(posedge clk)
	begin
		if (reset)
			in_frame <= 1'b0;
		else if (!dma_enable)
			in_frame <= 1'b0;
		else if (capture)
			in_frame <= ~stream_eop;
	end

	// Latch pixel, address and eop at the handshake
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			pixel_reg <= stream_data;
			addr_reg <= pixel_addr;
			eop_reg <= stream_eop;
		end
	end

	// Classic write cycle, held until ack
	assign master_cyc = (state == video_dma_pkg::ST_WRITE);
	assign master_stb = master_cyc;
	assign master_we = master_cyc;
	assign master_adr = addr_reg;
	// One byte lane, from the low address bits
	assign master_sel = video_dma_pkg::wb_sel_t'(1) << addr_reg[1:0];
	// Pixel copied to every lane
	assign master_dat_w = {4{pixel_reg}};

endmodule

`default_nettype wire

/* source/frame_address_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_address_gen (
	input logic clk,
	input logic reset,
	input logic addr_clear,
	input logic addr_step,
	input video_dma_pkg::wb_addr_t front_addr,
	output video_dma_pkg::wb_addr_t pixel_addr
);

	// Position of the next pixel in the frame
	video_dma_pkg::col_t col;
	video_dma_pkg::row_t row;
	// Offset from buffer start, row above column
	video_dma_pkg::wb_addr_t offset;

	// Column wraps at end of line, then row moves on
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			col <= '0;
			row <= '0;
		end
		else if (addr_clear)
		begin
			// Clear wins over step
			col <= '0;
			row <= '0;
		end
		else if (addr_step)
		begin
			if (col == video_dma_pkg::col_t'(video_dma_pkg::FRAME_WIDTH - 1))
			begin
				col <= '0;
				row <= row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

	// Start of frame pixel sees offset zero in its own cycle
	assign offset = addr_clear ? '0 : video_dma_pkg::wb_addr_t'({row, col});
	assign pixel_addr = front_addr + offset;

endmodule

`default_nettype wire

/* source/dma_control_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module dma_control_regs (
	input logic clk,
	input logic reset,
	input logic slave_cyc,
	input logic slave_stb,
	input logic slave_we,
	input video_dma_pkg::reg_index_t slave_adr,
	input video_dma_pkg::wb_sel_t slave_sel,
	input video_dma_pkg::wb_data_t slave_dat_w,
	input logic frame_done,
	output video_dma_pkg::wb_data_t slave_dat_r,
	output logic slave_ack,
	output video_dma_pkg::wb_addr_t front_addr,
	output logic dma_enable
);

	// Buffer written next after a swap
	video_dma_pkg::wb_addr_t back_addr;
	// Front write seen, waiting for end of frame
	logic swap_pending;
	// First cycle of a bus access, ack not yet given
	logic access;
	logic wr_access;
	// Composed read-back words
	video_dma_pkg::wb_data_t status_word;
	video_dma_pkg::wb_data_t status_merged;
	video_dma_pkg::wb_data_t resolution_word;

	// Replace only the byte lanes picked by sel
	function automatic video_dma_pkg::wb_data_t merge_bytes(
		input video_dma_pkg::wb_data_t old_word,
		input video_dma_pkg::wb_data_t new_word,
		input video_dma_pkg::wb_sel_t sel
	);
		video_dma_pkg::wb_data_t result;
		int i;
		result = old_word;
		for (i = 0; i < 4; i++)
		begin
			if (sel[i])
				result[8*i +: 8] = new_word[8*i +: 8];
		end
		return result;
	endfunction

	// Access starts while cyc and stb high and no ack out yet
	assign access = slave_cyc & slave_stb & ~slave_ack;
	assign wr_access = access & slave_we;

	// Status word, swap flag and enable only
	always_comb
	begin
		status_word = '0;
		status_word[video_dma_pkg::STATUS_SWAP_BIT] = swap_pending;
		status_word[video_dma_pkg::STATUS_ENABLE_BIT] = dma_enable;
	end

	// Enable bit after byte-select merge
	assign status_merged = merge_bytes(status_word, slave_dat_w, slave_sel);

	// Height high half, width low half
	assign resolution_word = {16'(video_dma_pkg::FRAME_HEIGHT),
		16'(video_dma_pkg::FRAME_WIDTH)};

	// One-cycle ack, one cycle after the request
	always_ff @(posedge clk)
	begin
		if (reset)
			slave_ack <= 1'b0;
		else
			slave_ack <= access;
	end

	// Registered read data, lines up with ack
	always_ff @(posedge clk)
	begin
		if (access)
		begin
			case (slave_adr)
				video_dma_pkg::REG_FRONT: slave_dat_r <= front_addr;
				video_dma_pkg::REG_BACK: slave_dat_r <= back_addr;
				video_dma_pkg::REG_RESOLUTION: slave_dat_r <= resolution_word;
				default: slave_dat_r <= status_word;
			endcase
		end
	end

	// Buffers, swap request and enable
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			front_addr <= video_dma_pkg::DEFAULT_FRONT_ADDR;
			back_addr <= video_dma_pkg::DEFAULT_BACK_ADDR;
			swap_pending <= 1'b0;
			dma_enable <= 1'b0;
		end
		else
		begin
			// Exchange only at a frame boundary
			if (frame_done && swap_pending)
			begin
				front_addr <= back_addr;
				back_addr <= front_addr;
				swap_pending <= 1'b0;
			end
			// Bus write comes last, a new request survives a same-cycle swap
			if (wr_access)
			begin
				case (slave_adr)
					// Front write only asks for the swap
					video_dma_pkg::REG_FRONT: swap_pending <= 1'b1;
					video_dma_pkg::REG_BACK:
						back_addr <= merge_bytes(back_addr, slave_dat_w, slave_sel);
					video_dma_pkg::REG_STATUS:
						dma_enable <= status_merged[video_dma_pkg::STATUS_ENABLE_BIT];
					// Resolution is read-only
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/video_dma_pkg.sv */
`default_nettype none

package video_dma_pkg;

	// Frame geometry, one byte per pixel
	localparam int FRAME_WIDTH = 8;
	localparam int FRAME_HEIGHT = 4;

	// Address field widths for column and row
	localparam int COL_BITS = 3;
	localparam int ROW_BITS = 2;

	// Payload and bus widths
	typedef logic [7:0] pixel_t;
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0] wb_sel_t;
	typedef logic [1:0] reg_index_t;

	// Pixel position inside the frame
	typedef logic [COL_BITS-1:0] col_t;
	typedef logic [ROW_BITS-1:0] row_t;

	// Buffer start addresses after reset
	localparam wb_addr_t DEFAULT_FRONT_ADDR = 32'h0000_1000;
	localparam wb_addr_t DEFAULT_BACK_ADDR = 32'h0000_2000;

	// Register map, word indices on the slave port
	localparam reg_index_t REG_FRONT = 2'd0;
	localparam reg_index_t REG_BACK = 2'd1;
	localparam reg_index_t REG_RESOLUTION = 2'd2;
	localparam reg_index_t REG_STATUS = 2'd3;

	// Status word bit positions
	localparam int STATUS_SWAP_BIT = 0;
	localparam int STATUS_ENABLE_BIT = 2;

	// Write engine states
	typedef enum logic {ST_IDLE, ST_WRITE} dma_state_t;

endpackage

`default_nettype wire
